/* source/rv_decode_defs.svh */
// Decode stage constants
`ifndef RV_DECODE_DEFS_SVH
`define RV_DECODE_DEFS_SVH

`define XLEN        32
`define REG_AW      5
`define UOP_W       5
`define NUM_FU      4

// Unit select bit positions
`define FU_ALU      0
`define FU_MUL      1
`define FU_LSI      2
`define FU_CFI      3

// Major opcodes, instruction bits 6 to 2
`define OPC_LUI     5'h0d
`define OPC_AUIPC   5'h05
`define OPC_JAL     5'h1b
`define OPC_JALR    5'h19
`define OPC_BRANCH  5'h18
`define OPC_LOAD    5'h00
`define OPC_STORE   5'h08
`define OPC_OPIMM   5'h04
`define OPC_OP      5'h0c
`define OPC_FENCE   5'h03

`define FN7_BASE    7'd0
`define FN7_ALT     7'd32
`define FN7_MULDIV  7'd1

`define ALU_ADD     5'b00_001
`define ALU_SUB     5'b00_000
`define ALU_AND     5'b01_001
`define ALU_OR      5'b01_010
`define ALU_XOR     5'b01_100
`define ALU_SLT     5'b10_001
`define ALU_SLTU    5'b10_010
`define ALU_SRA     5'b11_001
`define ALU_SRL     5'b11_010
`define ALU_SLL     5'b11_100

`define MUL_MUL     5'b01_000
`define MUL_MULH    5'b01_110
`define MUL_MULHSU  5'b01_111
`define MUL_MULHU   5'b01_101
`define MUL_DIV     5'b11_000
`define MUL_DIVU    5'b11_110
`define MUL_REM     5'b10_000
`define MUL_REMU    5'b10_111

`define CFI_BEQ     5'b00_001
`define CFI_BGE     5'b00_010
`define CFI_BGEU    5'b00_011
`define CFI_BLT     5'b00_100
`define CFI_BLTU    5'b00_101
`define CFI_BNE     5'b00_110
`define CFI_JAL     5'b10_010
`define CFI_JALR    5'b10_100

`define LSI_SIGNED  0
`define LSI_LOAD    3
`define LSI_STORE   4
`define LSI_BYTE    2'b01
`define LSI_HALF    2'b10
`define LSI_WORD    2'b11

// Tag vector layout, groups of 8 are in funct3 order
`define INS_W       46
`define INS_OP      0
`define INS_OPIMM   8
`define INS_MUL     16
`define INS_SUB     24
`define INS_SRA     25
`define INS_SRAI    26
`define INS_LUI     27
`define INS_AUIPC   28
`define INS_BR      29
`define INS_JAL     35
`define INS_JALR    36
`define INS_LD      37
`define INS_ST      42
`define INS_FENCE   45

`endif

/* source/rv_decode_pkg.sv */
// Decode stage types
`include "rv_decode_defs.svh"
`default_nettype none

package rv_decode_pkg;

    // Same word seen as R-type or I-type fields
    typedef union packed {
        struct packed {
            logic [6:0]         funct7;
            logic [`REG_AW-1:0] rs2;
            logic [`REG_AW-1:0] rs1;
            logic [2:0]         funct3;
            logic [`REG_AW-1:0] rd;
            logic [6:0]         opcode;
        } r;
        struct packed {
            logic [11:0]        imm12;
            logic [`REG_AW-1:0] rs1;
            logic [2:0]         funct3;
            logic [`REG_AW-1:0] rd;
            logic [6:0]         opcode;
        } i;
    } rv_instr_u;

    typedef struct packed {
        logic [`REG_AW-1:0] rd;
        logic [`XLEN-1:0]   op_a;
        logic [`XLEN-1:0]   op_b;
        logic [`UOP_W-1:0]  sub_opcode;
        logic [`NUM_FU-1:0] fu_sel;
        logic [1:0]         lsu_width;
        logic [`XLEN-1:0]   imm_pc;
        logic               illegal;
    } dispatch_t;

endpackage

`default_nettype wire

/* source/decode_if.sv */
// Classification bus
`timescale 1ns/10ps
`include "rv_decode_defs.svh"
`default_nettype none

interface decode_if;
    logic [`NUM_FU-1:0] fu_sel;
    logic               imm_i;
    logic               imm_s;
    logic               imm_b;
    logic               imm_u;
    logic               imm_j;
    logic               imm_sh;
    logic               a_rs1;
    logic               a_pc;
    logic               b_rs2;
    logic               b_imm;
    logic               no_rd;     // Stores and branches
    logic               illegal;
    logic [`INS_W-1:0]  ins;       // One-hot instruction tag

    modport producer (output fu_sel, imm_i, imm_s, imm_b, imm_u, imm_j, imm_sh,
                      a_rs1, a_pc, b_rs2, b_imm, no_rd, illegal, ins);
    modport consumer (input fu_sel, imm_i, imm_s, imm_b, imm_u, imm_j, imm_sh,
                      a_rs1, a_pc, b_rs2, b_imm, no_rd, illegal, ins);
endinterface

`default_nettype wire

/* source/instr_classifier.sv */
// RV32IM instruction classifier
`timescale 1ns/10ps
`include "rv_decode_defs.svh"
`default_nettype none

module instr_classifier (
    input  rv_decode_pkg::rv_instr_u inst,
    decode_if.producer               dif
);

    logic               std_len;
    logic [4:0]         opc;
    logic [2:0]         f3;
    logic               is_op;
    logic               is_imm;
    logic [`INS_W-1:0]  tag;
    logic [`NUM_FU-1:0] fu;
    logic               alu_rr;
    logic               alu_ri;
    logic               br_any;
    logic               ld_any;
    logic               st_any;
    logic               shift_imm;

    assign std_len = inst.r.opcode[1:0] == 2'b11;   // 32-bit encodings only
    assign opc     = inst.r.opcode[6:2];
    assign f3      = inst.r.funct3;
    assign is_op   = std_len && opc == `OPC_OP;
    assign is_imm  = std_len && opc == `OPC_OPIMM;

    always_comb begin
        tag = '0;
        for (int k = 0; k < 8; k++) begin
            tag[`INS_OP + k]  = is_op && inst.r.funct7 == `FN7_BASE && f3 == 3'(k);
            tag[`INS_MUL + k] = is_op && inst.r.funct7 == `FN7_MULDIV && f3 == 3'(k);
            // slli and srli also need a clean funct7
            tag[`INS_OPIMM + k] = is_imm && f3 == 3'(k) &&
                                  (f3[1:0] != 2'b01 || inst.r.funct7 == `FN7_BASE);
        end
        for (int k = 0; k < 6; k++) begin
            tag[`INS_BR + k] = std_len && opc == `OPC_BRANCH && f3 == 3'(k < 2 ? k : k + 2);
        end
        for (int k = 0; k < 5; k++) begin
            tag[`INS_LD + k] = std_len && opc == `OPC_LOAD && f3 == 3'(k < 3 ? k : k + 1);
        end
        for (int k = 0; k < 3; k++) begin
            tag[`INS_ST + k] = std_len && opc == `OPC_STORE && f3 == 3'(k);
        end
        tag[`INS_SUB]   = is_op && inst.r.funct7 == `FN7_ALT && f3 == 3'd0;
        tag[`INS_SRA]   = is_op && inst.r.funct7 == `FN7_ALT && f3 == 3'd5;
        tag[`INS_SRAI]  = is_imm && inst.r.funct7 == `FN7_ALT && f3 == 3'd5;
        tag[`INS_LUI]   = std_len && opc == `OPC_LUI;
        tag[`INS_AUIPC] = std_len && opc == `OPC_AUIPC;
        tag[`INS_JAL]   = std_len && opc == `OPC_JAL;
        tag[`INS_JALR]  = std_len && opc == `OPC_JALR && f3 == 3'd0;
        tag[`INS_FENCE] = std_len && opc == `OPC_FENCE && f3 == 3'd0;
    end

    assign alu_rr    = |tag[`INS_OP +: 8] || tag[`INS_SUB] || tag[`INS_SRA];
    assign alu_ri    = |tag[`INS_OPIMM +: 8] || tag[`INS_SRAI];
    assign br_any    = |tag[`INS_BR +: 6];
    assign ld_any    = |tag[`INS_LD +: 5];
    assign st_any    = |tag[`INS_ST +: 3];
    assign shift_imm = tag[`INS_OPIMM + 1] || tag[`INS_OPIMM + 5] || tag[`INS_SRAI];

    always_comb begin
        fu          = '0;
        fu[`FU_ALU] = alu_rr || alu_ri || tag[`INS_LUI] || tag[`INS_AUIPC];
        fu[`FU_MUL] = |tag[`INS_MUL +: 8];
        fu[`FU_LSI] = ld_any || st_any;
        fu[`FU_CFI] = br_any || tag[`INS_JAL] || tag[`INS_JALR];
    end

    assign dif.fu_sel  = fu;   // FENCE selects nothing
    assign dif.imm_i   = (alu_ri && !shift_imm) || tag[`INS_JALR] || ld_any;
    assign dif.imm_s   = st_any;
    assign dif.imm_b   = br_any;
    assign dif.imm_u   = tag[`INS_LUI] || tag[`INS_AUIPC];
    assign dif.imm_j   = tag[`INS_JAL];
    assign dif.imm_sh  = shift_imm;
    assign dif.a_rs1   = alu_rr || alu_ri || fu[`FU_MUL] || br_any || tag[`INS_JALR] ||
                         ld_any || st_any;
    assign dif.a_pc    = tag[`INS_AUIPC];
    assign dif.b_rs2   = alu_rr || fu[`FU_MUL] || br_any;
    assign dif.b_imm   = alu_ri || dif.imm_u || tag[`INS_JALR] || ld_any || st_any;
    assign dif.no_rd   = st_any || br_any;
    assign dif.illegal = ~|tag;
    assign dif.ins     = tag;

endmodule

`default_nettype wire

/* source/uop_encoder.sv */
// Sub-opcode encoder
`timescale 1ns/10ps
`include "rv_decode_defs.svh"
`default_nettype none

module uop_encoder (
    decode_if.consumer          dif,
    output logic [`UOP_W-1:0]   sub_opcode,
    output logic [1:0]          lsu_width
);

    // Indexed by funct3
    localparam logic [`UOP_W-1:0] ALU_TAB [8] = '{`ALU_ADD, `ALU_SLL, `ALU_SLT, `ALU_SLTU,
                                                  `ALU_XOR, `ALU_SRL, `ALU_OR, `ALU_AND};
    localparam logic [`UOP_W-1:0] MUL_TAB [8] = '{`MUL_MUL, `MUL_MULH, `MUL_MULHSU,
                                                  `MUL_MULHU, `MUL_DIV, `MUL_DIVU,
                                                  `MUL_REM, `MUL_REMU};
    // Tag order beq bne blt bge bltu bgeu
    localparam logic [`UOP_W-1:0] BR_TAB [6] = '{`CFI_BEQ, `CFI_BNE, `CFI_BLT, `CFI_BGE,
                                                 `CFI_BLTU, `CFI_BGEU};
    localparam logic [1:0] WIDTH_TAB [5] = '{`LSI_BYTE, `LSI_HALF, `LSI_WORD,
                                             `LSI_BYTE, `LSI_HALF};

    logic [`UOP_W-1:0] uop_alu;
    logic [`UOP_W-1:0] uop_mul;
    logic [`UOP_W-1:0] uop_cfi;
    logic [`UOP_W-1:0] uop_lsi;

    always_comb begin
        uop_alu   = '0;
        uop_mul   = '0;
        uop_cfi   = '0;
        uop_lsi   = '0;
        lsu_width = '0;
        for (int k = 0; k < 8; k++) begin
            if (dif.ins[`INS_OP + k] || dif.ins[`INS_OPIMM + k])
                uop_alu = uop_alu | ALU_TAB[k];
            if (dif.ins[`INS_MUL + k])
                uop_mul = uop_mul | MUL_TAB[k];
        end
        if (dif.ins[`INS_SRA] || dif.ins[`INS_SRAI])
            uop_alu = uop_alu | `ALU_SRA;
        if (dif.ins[`INS_LUI])
            uop_alu = uop_alu | `ALU_OR;        // rd = 0 | imm
        if (dif.ins[`INS_AUIPC])
            uop_alu = uop_alu | `ALU_ADD;       // sub is all zero
        for (int k = 0; k < 6; k++) begin
            if (dif.ins[`INS_BR + k])
                uop_cfi = uop_cfi | BR_TAB[k];
        end
        if (dif.ins[`INS_JAL])
            uop_cfi = uop_cfi | `CFI_JAL;
        if (dif.ins[`INS_JALR])
            uop_cfi = uop_cfi | `CFI_JALR;
        for (int k = 0; k < 5; k++) begin
            if (dif.ins[`INS_LD + k])
                lsu_width = lsu_width | WIDTH_TAB[k];
        end
        for (int k = 0; k < 3; k++) begin
            if (dif.ins[`INS_ST + k])
                lsu_width = lsu_width | WIDTH_TAB[k];
        end
        uop_lsi[2:1]        = lsu_width;
        uop_lsi[`LSI_LOAD]   = |dif.ins[`INS_LD +: 5];
        uop_lsi[`LSI_STORE]  = |dif.ins[`INS_ST +: 3];
        uop_lsi[`LSI_SIGNED] = dif.ins[`INS_LD] || dif.ins[`INS_LD + 1];   // lb, lh
        sub_opcode = uop_alu | uop_mul | uop_cfi | uop_lsi;
    end

endmodule

`default_nettype wire

/* source/imm_generator.sv */
// Immediate generator
`timescale 1ns/10ps
`include "rv_decode_defs.svh"
`default_nettype none

module imm_generator (
    input  rv_decode_pkg::rv_instr_u inst,
    decode_if.consumer               dif,
    output logic [`XLEN-1:0]         imm,
    output logic [`XLEN-1:0]         imm_pc
);

    logic             sign;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_j;
    logic [`XLEN-1:0] imm_sh;

    assign sign   = inst.i.imm12[11];
    assign imm_i  = {{20{sign}}, inst.i.imm12};
    assign imm_s  = {{20{sign}}, inst.i.imm12[11:5], inst.i.rd};
    assign imm_b  = {{19{sign}}, sign, inst.i.rd[0], inst.i.imm12[10:5], inst.i.rd[4:1], 1'b0};
    assign imm_u  = {inst.i.imm12, inst.i.rs1, inst.i.funct3, 12'b0};
    assign imm_j  = {{11{sign}}, sign, inst.i.rs1, inst.i.funct3, inst.i.imm12[0],
                     inst.i.imm12[10:1], 1'b0};
    assign imm_sh = {27'b0, inst.i.imm12[4:0]};    // Shamt

    assign imm_pc = {`XLEN{dif.imm_b}} & imm_b |
                    {`XLEN{dif.imm_j}} & imm_j |
                    {`XLEN{dif.imm_u}} & imm_u;

    assign imm = imm_pc |
                 {`XLEN{dif.imm_i}}  & imm_i |
                 {`XLEN{dif.imm_s}}  & imm_s |
                 {`XLEN{dif.imm_sh}} & imm_sh;

endmodule

`default_nettype wire

/* source/operand_select.sv */
// Operand and destination select
`timescale 1ns/10ps
`include "rv_decode_defs.svh"
`default_nettype none

module operand_select (
    input  rv_decode_pkg::rv_instr_u  inst,
    input  logic [`XLEN-1:0]          rs1_data,
    input  logic [`XLEN-1:0]          rs2_data,
    input  logic [`XLEN-1:0]          pc,
    input  logic [`XLEN-1:0]          imm,
    decode_if.consumer                dif,
    input  logic [`UOP_W-1:0]         sub_opcode,
    input  logic [1:0]                lsu_width,
    input  logic [`XLEN-1:0]          imm_pc,
    output rv_decode_pkg::dispatch_t  bundle
);

    always_comb begin
        bundle.op_a = {`XLEN{dif.a_rs1}} & rs1_data |
                      {`XLEN{dif.a_pc}}  & pc;
        bundle.op_b = {`XLEN{dif.b_rs2}} & rs2_data |
                      {`XLEN{dif.b_imm}} & imm;
        // No write back for stores, branches, FENCE or illegal words
        bundle.rd         = (dif.no_rd || dif.fu_sel == '0) ? '0 : inst.i.rd;
        bundle.sub_opcode = sub_opcode;
        bundle.fu_sel     = dif.fu_sel;
        bundle.lsu_width  = lsu_width;
        bundle.imm_pc     = imm_pc;
        bundle.illegal    = dif.illegal;
    end

endmodule

`default_nettype wire

/* source/dispatch_register.sv */
// Dispatch pipeline register
`timescale 1ns/10ps
`include "rv_decode_defs.svh"
`default_nettype none

module dispatch_register (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      inst_valid,
    input  rv_decode_pkg::dispatch_t  next,
    output logic                      dec_valid,
    output rv_decode_pkg::dispatch_t  current
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
            current   <= '0;
        end else begin
            dec_valid <= inst_valid;     // One pulse per accepted word
            if (inst_valid) begin
                current <= next;
            end
        end
    end

endmodule

`default_nettype wire

/* source/rv_decode_top.sv */
// RV32IM decode stage
`timescale 1ns/10ps
`include "rv_decode_defs.svh"
`default_nettype none

module rv_decode_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                inst_valid,
    input  logic [`XLEN-1:0]    inst,
    input  logic [`XLEN-1:0]    rs1_data,
    input  logic [`XLEN-1:0]    rs2_data,
    input  logic [`XLEN-1:0]    pc,
    output logic [`REG_AW-1:0]  rs1_addr,
    output logic [`REG_AW-1:0]  rs2_addr,
    output logic                dec_valid,
    output logic [`REG_AW-1:0]  rd_addr,
    output logic [`XLEN-1:0]    op_a,
    output logic [`XLEN-1:0]    op_b,
    output logic [`UOP_W-1:0]   sub_opcode,
    output logic [`NUM_FU-1:0]  fu_sel,
    output logic [1:0]          lsu_width,
    output logic [`XLEN-1:0]    imm_pc,
    output logic                illegal
);

    rv_decode_pkg::dispatch_t next_bundle;
    rv_decode_pkg::dispatch_t cur_bundle;
    logic [`UOP_W-1:0]        uop;
    logic [1:0]               width;
    logic [`XLEN-1:0]         imm;
    logic [`XLEN-1:0]         imm_pc_w;

    decode_if dif ();

    instr_classifier classifier_i (.inst(inst), .dif(dif.producer));

    uop_encoder uop_encoder_i (.dif(dif.consumer), .sub_opcode(uop), .lsu_width(width));

    imm_generator imm_generator_i (
        .inst   (inst),
        .dif    (dif.consumer),
        .imm    (imm),
        .imm_pc (imm_pc_w)
    );

    operand_select operand_select_i (
        .inst       (inst),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .pc         (pc),
        .imm        (imm),
        .dif        (dif.consumer),
        .sub_opcode (uop),
        .lsu_width  (width),
        .imm_pc     (imm_pc_w),
        .bundle     (next_bundle)
    );

    dispatch_register dispatch_register_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .next       (next_bundle),
        .dec_valid  (dec_valid),
        .current    (cur_bundle)
    );

    // Register file reads stay in the decode cycle
    assign rs1_addr   = inst[19:15];
    assign rs2_addr   = inst[24:20];
    assign rd_addr    = cur_bundle.rd;
    assign op_a       = cur_bundle.op_a;
    assign op_b       = cur_bundle.op_b;
    assign sub_opcode = cur_bundle.sub_opcode;
    assign fu_sel     = cur_bundle.fu_sel;
    assign lsu_width  = cur_bundle.lsu_width;
    assign imm_pc     = cur_bundle.imm_pc;
    assign illegal    = cur_bundle.illegal;

endmodule

`default_nettype wire

/* tests/rv_decode_properties.sv */
// Decode stage assertions
`timescale 1ns/10ps
`include "rv_decode_defs.svh"
`default_nettype none

module rv_decode_properties (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [`XLEN-1:0]    inst,
    input  logic [`REG_AW-1:0]  rs1_addr,
    input  logic                dec_valid,
    input  logic [`NUM_FU-1:0]  fu_sel,
    input  logic [`REG_AW-1:0]  rd_addr,
    input  logic                illegal
);

    int assert_fails = 0;

    a_fu_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(fu_sel))
        else begin
            $error("fu_sel has more than one unit selected");
            assert_fails++;
        end

    a_illegal_quiet: assert property (@(posedge clk) disable iff (!rst_n)
                                      illegal |-> (fu_sel == '0 && rd_addr == '0))
        else begin
            $error("Illegal word selects a unit or a destination");
            assert_fails++;
        end

    a_reset_valid: assert property (@(posedge clk) !rst_n |=> !dec_valid)
        else begin
            $error("dec_valid high right after reset");
            assert_fails++;
        end

    // Register read address is a straight field slice
    a_rs1_field: assert property (@(posedge clk) rs1_addr == inst[19:15])
        else begin
            $error("rs1_addr does not follow inst");
            assert_fails++;
        end

endmodule

bind rv_decode_top rv_decode_properties props_i (.*);

`default_nettype wire

/* tests/rv_decode_checker.sv */
// Decode output checker
`timescale 1ns/10ps
`include "rv_decode_defs.svh"
`default_nettype none

module rv_decode_checker (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     inst_valid,
    input  logic [`XLEN-1:0]         inst,
    input  rv_decode_pkg::dispatch_t exp_next,
    input  logic [`REG_AW-1:0]       rs1_addr,
    input  logic [`REG_AW-1:0]       rs2_addr,
    input  logic                     dec_valid,
    input  logic [`REG_AW-1:0]       rd_addr,
    input  logic [`XLEN-1:0]         op_a,
    input  logic [`XLEN-1:0]         op_b,
    input  logic [`UOP_W-1:0]        sub_opcode,
    input  logic [`NUM_FU-1:0]       fu_sel,
    input  logic [1:0]               lsu_width,
    input  logic [`XLEN-1:0]         imm_pc,
    input  logic                     illegal,
    output int                       errors,
    output int                       checked
);

    rv_decode_pkg::dispatch_t exp_q;     // Last accepted word
    logic                     exp_valid;
    int                       err_cnt = 0;
    int                       chk_cnt = 0;

    assign errors  = err_cnt;
    assign checked = chk_cnt;

    task automatic compare(input string name, input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp) begin
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            exp_valid <= 1'b0;
            exp_q     <= '0;
        end else begin
            exp_valid <= inst_valid;
            if (inst_valid)
                exp_q <= exp_next;
        end
    end

    // Outputs settle well before the falling edge
    always @(negedge clk) begin
        compare("rs1_addr", 32'(rs1_addr), 32'(inst[19:15]));
        compare("rs2_addr", 32'(rs2_addr), 32'(inst[24:20]));
        compare("dec_valid", 32'(dec_valid), 32'(exp_valid));
        compare("rd_addr", 32'(rd_addr), 32'(exp_q.rd));     // Held between strobes too
        compare("op_a", op_a, exp_q.op_a);
        compare("op_b", op_b, exp_q.op_b);
        compare("sub_opcode", 32'(sub_opcode), 32'(exp_q.sub_opcode));
        compare("fu_sel", 32'(fu_sel), 32'(exp_q.fu_sel));
        compare("lsu_width", 32'(lsu_width), 32'(exp_q.lsu_width));
        compare("imm_pc", imm_pc, exp_q.imm_pc);
        compare("illegal", 32'(illegal), 32'(exp_q.illegal));
        if (dec_valid)
            chk_cnt++;
    end

endmodule

`default_nettype wire

/* tests/rv_decode_tb.sv */
// Decode stage testbench
`timescale 1ns/10ps
`include "rv_decode_defs.svh"
`default_nettype none

module rv_decode_tb;

    localparam int NUM_INSTR    = 400;
    localparam int RESET_CYCLES = 8;
    localparam int MAX_CYCLES   = NUM_INSTR * 3 / 2;   // ~4/3 cycles per word plus slack

    logic                     clk = 1'b0;
    logic                     rst_n;
    logic                     inst_valid;
    logic [`XLEN-1:0]         inst;
    logic [`XLEN-1:0]         rs1_data;
    logic [`XLEN-1:0]         rs2_data;
    logic [`XLEN-1:0]         pc;
    logic [`REG_AW-1:0]       rs1_addr;
    logic [`REG_AW-1:0]       rs2_addr;
    logic                     dec_valid;
    logic [`REG_AW-1:0]       rd_addr;
    logic [`XLEN-1:0]         op_a;
    logic [`XLEN-1:0]         op_b;
    logic [`UOP_W-1:0]        sub_opcode;
    logic [`NUM_FU-1:0]       fu_sel;
    logic [1:0]               lsu_width;
    logic [`XLEN-1:0]         imm_pc;
    logic                     illegal;
    rv_decode_pkg::dispatch_t exp_next;
    logic [31:0]              seed = 32'ha7ec_d801;
    logic [31:0]              pick;
    int                       sent;
    int                       cycle_count;
    int                       errors;
    int                       checked;
    int                       total;

    always #50 clk = ~clk;

    // Low LCG bits have short periods, so fold the upper half into them
    function automatic logic [31:0] rand32();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed ^ (seed >> 16);
    endfunction

    function automatic logic [4:0] alu_code(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0: return alt ? `ALU_SUB : `ALU_ADD;
            3'd1: return `ALU_SLL;
            3'd2: return `ALU_SLT;
            3'd3: return `ALU_SLTU;
            3'd4: return `ALU_XOR;
            3'd5: return alt ? `ALU_SRA : `ALU_SRL;
            3'd6: return `ALU_OR;
            default: return `ALU_AND;
        endcase
    endfunction

    function automatic logic [4:0] mul_code(input logic [2:0] f3);
        case (f3)
            3'd0: return `MUL_MUL;
            3'd1: return `MUL_MULH;
            3'd2: return `MUL_MULHSU;
            3'd3: return `MUL_MULHU;
            3'd4: return `MUL_DIV;
            3'd5: return `MUL_DIVU;
            3'd6: return `MUL_REM;
            default: return `MUL_REMU;
        endcase
    endfunction

    function automatic logic [4:0] branch_code(input logic [2:0] f3);
        case (f3)
            3'd0: return `CFI_BEQ;
            3'd1: return `CFI_BNE;
            3'd4: return `CFI_BLT;
            3'd5: return `CFI_BGE;
            3'd6: return `CFI_BLTU;
            default: return `CFI_BGEU;
        endcase
    endfunction

    // Expected dispatch bundle for one word, register data and PC
    function automatic rv_decode_pkg::dispatch_t decode_ref(input logic [31:0] w,
            input logic [31:0] a, input logic [31:0] b, input logic [31:0] p);
        rv_decode_pkg::dispatch_t d;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic        legal;
        logic        keep_rd;
        logic        shift;
        logic [1:0]  width;
        logic [31:0] imm_i;
        logic [31:0] imm_u;
        d       = '0;
        f3      = w[14:12];
        f7      = w[31:25];
        legal   = 1'b0;
        keep_rd = 1'b0;
        shift   = f3[1:0] == 2'b01;
        width   = f3[1:0] == 2'd0 ? `LSI_BYTE : f3[1:0] == 2'd1 ? `LSI_HALF : `LSI_WORD;
        imm_i   = {{20{w[31]}}, w[31:20]};
        imm_u   = {w[31:12], 12'b0};
        if (w[1:0] == 2'b11) begin
            case (w[6:2])
                `OPC_OP: begin
                    if (f7 == `FN7_BASE || (f7 == `FN7_ALT && (f3 == 3'd0 || f3 == 3'd5))) begin
                        legal = 1'b1;
                        d.fu_sel[`FU_ALU] = 1'b1;
                        d.sub_opcode = alu_code(f3, f7 == `FN7_ALT);
                    end else if (f7 == `FN7_MULDIV) begin
                        legal = 1'b1;
                        d.fu_sel[`FU_MUL] = 1'b1;
                        d.sub_opcode = mul_code(f3);
                    end
                    keep_rd = legal;
                    d.op_a  = legal ? a : '0;
                    d.op_b  = legal ? b : '0;
                end
                `OPC_OPIMM: begin
                    if (!shift || f7 == `FN7_BASE || (f3 == 3'd5 && f7 == `FN7_ALT)) begin
                        legal   = 1'b1;
                        keep_rd = 1'b1;
                        d.fu_sel[`FU_ALU] = 1'b1;
                        d.sub_opcode = alu_code(f3, f3 == 3'd5 && f7 == `FN7_ALT);
                        d.op_a = a;
                        d.op_b = shift ? {27'b0, w[24:20]} : imm_i;
                    end
                end
                `OPC_LUI, `OPC_AUIPC: begin
                    legal   = 1'b1;
                    keep_rd = 1'b1;
                    d.fu_sel[`FU_ALU] = 1'b1;
                    d.sub_opcode = w[6:2] == `OPC_LUI ? `ALU_OR : `ALU_ADD;
                    d.op_a   = w[6:2] == `OPC_LUI ? '0 : p;
                    d.op_b   = imm_u;
                    d.imm_pc = imm_u;
                end
                `OPC_BRANCH: begin
                    if (f3 != 3'd2 && f3 != 3'd3) begin
                        legal = 1'b1;
                        d.fu_sel[`FU_CFI] = 1'b1;
                        d.sub_opcode = branch_code(f3);
                        d.op_a   = a;
                        d.op_b   = b;
                        d.imm_pc = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                    end
                end
                `OPC_JAL: begin
                    legal   = 1'b1;
                    keep_rd = 1'b1;
                    d.fu_sel[`FU_CFI] = 1'b1;
                    d.sub_opcode = `CFI_JAL;
                    d.imm_pc = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                end
                `OPC_JALR: begin
                    if (f3 == 3'd0) begin
                        legal   = 1'b1;
                        keep_rd = 1'b1;
                        d.fu_sel[`FU_CFI] = 1'b1;
                        d.sub_opcode = `CFI_JALR;
                        d.op_a = a;
                        d.op_b = imm_i;
                    end
                end
                `OPC_LOAD: begin
                    if (f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5}) begin
                        legal   = 1'b1;
                        keep_rd = 1'b1;
                        d.fu_sel[`FU_LSI] = 1'b1;
                        d.lsu_width = width;
                        d.sub_opcode[2:1]         = width;
                        d.sub_opcode[`LSI_LOAD]   = 1'b1;
                        d.sub_opcode[`LSI_SIGNED] = f3 == 3'd0 || f3 == 3'd1;   // lb, lh
                        d.op_a = a;
                        d.op_b = imm_i;
                    end
                end
                `OPC_STORE: begin
                    if (f3 inside {3'd0, 3'd1, 3'd2}) begin
                        legal = 1'b1;
                        d.fu_sel[`FU_LSI] = 1'b1;
                        d.lsu_width = width;
                        d.sub_opcode[2:1]        = width;
                        d.sub_opcode[`LSI_STORE] = 1'b1;
                        d.op_a = a;
                        d.op_b = {{20{w[31]}}, w[31:25], w[11:7]};
                    end
                end
                `OPC_FENCE: legal = f3 == 3'd0;     // Legal but no unit
                default: legal = 1'b0;
            endcase
        end
        d.rd      = keep_rd ? w[11:7] : '0;
        d.illegal = !legal;
        return d;
    endfunction

    // Random word from one of 16 templates
    function automatic logic [31:0] make_instr();
        logic [31:0] w;
        logic [31:0] r;
        w = rand32();
        r = rand32();
        case (r[31:28])
            4'd0, 4'd1: w = {`FN7_BASE, w[24:7], `OPC_OP, 2'b11};
            4'd2: w = {`FN7_ALT, w[24:15], r[0] ? 3'd5 : 3'd0, w[11:7], `OPC_OP, 2'b11};
            4'd3, 4'd4: w = {`FN7_MULDIV, w[24:7], `OPC_OP, 2'b11};
            4'd5, 4'd6: begin
                w = {w[31:7], `OPC_OPIMM, 2'b11};
                if (w[13:12] == 2'b01)
                    w[31:25] = r[1] ? `FN7_ALT : `FN7_BASE;
            end
            4'd7: w = {w[31:7], r[0] ? `OPC_LUI : `OPC_AUIPC, 2'b11};
            4'd8: w = {w[31:7], `OPC_BRANCH, 2'b11};
            4'd9: w = r[0] ? {w[31:7], `OPC_JAL, 2'b11}
                           : {w[31:15], 3'd0, w[11:7], `OPC_JALR, 2'b11};
            4'd10: w = {w[31:7], `OPC_LOAD, 2'b11};
            4'd11: w = {w[31:7], `OPC_STORE, 2'b11};
            4'd12: w = {w[31:15], 3'd0, w[11:7], `OPC_FENCE, 2'b11};
            4'd13: w = {w[31:7], 5'h1c, 2'b11};            // CSR and system
            4'd14: w = w;
            default: w = {r[27:21], w[24:7], `OPC_OP, 2'b11};   // Odd funct7
        endcase
        return w;
    endfunction

    always_comb exp_next = decode_ref(inst, rs1_data, rs2_data, pc);

    rv_decode_top rv_decode_top_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .pc         (pc),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .dec_valid  (dec_valid),
        .rd_addr    (rd_addr),
        .op_a       (op_a),
        .op_b       (op_b),
        .sub_opcode (sub_opcode),
        .fu_sel     (fu_sel),
        .lsu_width  (lsu_width),
        .imm_pc     (imm_pc),
        .illegal    (illegal)
    );

    rv_decode_checker checker_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .exp_next   (exp_next),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .dec_valid  (dec_valid),
        .rd_addr    (rd_addr),
        .op_a       (op_a),
        .op_b       (op_b),
        .sub_opcode (sub_opcode),
        .fu_sel     (fu_sel),
        .lsu_width  (lsu_width),
        .imm_pc     (imm_pc),
        .illegal    (illegal),
        .errors     (errors),
        .checked    (checked)
    );

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("Checks failed");
        $finish;
    end

    initial begin
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        rs1_data   = '0;
        rs2_data   = '0;
        pc         = '0;
        sent       = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        while (sent < NUM_INSTR) begin
            @(posedge clk);
            pick = rand32();
            inst_valid <= pick[31:30] != 2'b00;    // About 3 of 4 cycles
            inst       <= make_instr();
            rs1_data   <= rand32();
            rs2_data   <= rand32();
            pc         <= rand32() & 32'hffff_fffc;
            if (pick[31:30] != 2'b00)
                sent++;
        end
        @(posedge clk);
        inst_valid <= 1'b0;
        repeat (3) @(posedge clk);
        total = errors + rv_decode_top_i.props_i.assert_fails;
        if (checked != NUM_INSTR) begin
            $display("Expected %0d decoded results but saw %0d", NUM_INSTR, checked);
            total++;
        end
        $display("Errors: %0d, results checked: %0d", total, checked);
        if (total == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+source
source/rv_decode_pkg.sv
source/decode_if.sv
source/instr_classifier.sv
source/uop_encoder.sv
source/imm_generator.sv
source/operand_select.sv
source/dispatch_register.sv
source/rv_decode_top.sv
tests/rv_decode_properties.sv
tests/rv_decode_checker.sv
tests/rv_decode_tb.sv

/* Bender.yml */
package:
  name: rv_decode

sources:
  - include_dirs:
      - source
    files:
      - source/rv_decode_pkg.sv
      - source/decode_if.sv
      - source/instr_classifier.sv
      - source/uop_encoder.sv
      - source/imm_generator.sv
      - source/operand_select.sv
      - source/dispatch_register.sv
      - source/rv_decode_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/rv_decode_properties.sv
      - tests/rv_decode_checker.sv
      - tests/rv_decode_tb.sv
